// ==== build.f ====
design/ctrlport_pkg.sv
design/ctrlport_reg_ro.sv
design/ctrlport_reg_rw.sv
design/ctrlport_resp_merge.sv
design/status_counters.sv
design/ctrlport_status_block.sv
tb/ctrlport_status_block_tb.sv

// ==== Makefile ====
# Verilator simulation of the control-port status block
VERILATOR ?= verilator
TOP       ?= ctrlport_status_block_tb
FILE_LIST ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_TEXT ?= All tests passed

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tb/ctrlport_status_block_tb.sv ====
module ctrlport_status_block_tb
  import ctrlport_pkg::*;
();

  localparam int clk_period = 4;
  // Cycle budget per test: scratch, errors, preset, timestamp, events
  localparam int budget_cycles = 40 + 40 + 60 + 150 + 200;
  localparam int watchdog_cycles = budget_cycles + 100;

  // Expected reply; the data is compared only when check is set
  typedef struct packed {
    logic           check;
    ctrlport_resp_t resp;
  } expect_t;

  logic           ctrlport_clk = 1'b0;
  logic           rst_n = 1'b0;
  ctrlport_req_t  s_req = '0;
  ctrlport_resp_t s_resp;
  logic           event_strobe = 1'b0;

  expect_t     exp_q[$];
  expect_t     exp_resp = '0;
  logic [15:0] lfsr_state = 16'd58401;
  int          cycle_cnt = 0;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  ctrlport_status_block i_dut (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (s_resp),
    .event_strobe (event_strobe)
  );

  always #(clk_period / 2) ctrlport_clk = ~ctrlport_clk;

  always @(posedge ctrlport_clk) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // ----------------------------------------------------------------------
  // Response model and checks
  // ----------------------------------------------------------------------

  // One expectation leaves the queue for each strobe the DUT samples,
  // so exp_resp lines up with the reply one cycle later
  always @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_resp <= '0;
    end else if ((s_req.rd || s_req.wr) && exp_q.size() > 0) begin
      exp_resp <= exp_q.pop_front();
    end else begin
      exp_resp <= '0;
    end
  end

  a_ack_after_strobe : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    (s_req.rd || s_req.wr) |=> s_resp.ack
  ) else begin
    errors++;
    $display("a strobe got no ack in the next cycle, time %0t", $time);
  end

  a_no_stray_ack : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    !(s_req.rd || s_req.wr) |=> !s_resp.ack
  ) else begin
    errors++;
    $display("an ack came without a request before it, time %0t", $time);
  end

  a_resp_status : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    exp_resp.resp.ack |-> (s_resp.status == exp_resp.resp.status)
  ) else begin
    errors++;
    $display("error at %0t: status %0d, expected %0d", $time,
             $sampled(s_resp.status), $sampled(exp_resp.resp.status));
  end

  a_resp_data : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    (exp_resp.resp.ack && exp_resp.check) |-> (s_resp.data == exp_resp.resp.data)
  ) else begin
    errors++;
    $display("error at %0t: data %h, expected %h", $time,
             $sampled(s_resp.data), $sampled(exp_resp.resp.data));
  end

  // ----------------------------------------------------------------------
  // Random numbers and bus tasks
  // ----------------------------------------------------------------------

  // Taps 16, 14, 13 and 11 give a maximal-length sequence
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      r = {r[62:0], lfsr_state[0]};
    end
    return r;
  endfunction

  // Drives one strobe on the falling edge and queues its reply.
  // A following call drives the next strobe in the very next cycle
  task automatic issue(input logic wr, input logic [19:0] addr, input logic [31:0] wdata,
                       input logic [1:0] status, input logic [31:0] rdata,
                       input logic check);
    expect_t e;
    e.check       = check;
    e.resp.ack    = 1'b1;
    e.resp.status = status;
    // Writes and address errors answer with zero data
    e.resp.data   = (wr || status != status_okay) ? 32'd0 : rdata;
    @(negedge ctrlport_clk);
    s_req.wr   = wr;
    s_req.rd   = !wr;
    s_req.addr = addr;
    s_req.data = wr ? wdata : 32'd0;
    exp_q.push_back(e);
  endtask

  // Drops the strobe and waits for the reply to the last request
  task automatic end_burst(output logic [31:0] rdata);
    int waited;
    waited = 0;
    @(negedge ctrlport_clk);
    s_req = '0;
    while (!s_resp.ack && waited < 8) begin
      @(negedge ctrlport_clk);
      waited++;
    end
    if (!s_resp.ack) begin
      errors++;
      $display("no reply arrived for the last request, time %0t", $time);
    end
    rdata = s_resp.data;
  endtask

  task automatic wr_reg(input logic [19:0] addr, input logic [31:0] wdata,
                        input logic [1:0] status);
    logic [31:0] unused;
    issue(1'b1, addr, wdata, status, 32'd0, 1'b1);
    end_burst(unused);
  endtask

  task automatic rd_reg(input logic [19:0] addr, input logic [1:0] status,
                        input logic [31:0] expected, input logic check,
                        output logic [31:0] rdata);
    issue(1'b0, addr, 32'd0, status, expected, check);
    end_burst(rdata);
  endtask

  // Sends n event strobes, either all high or LFSR chosen, and counts them
  task automatic pulse_events(input int n, input logic random, output int sent);
    sent = 0;
    for (int i = 0; i < n; i++) begin
      @(negedge ctrlport_clk);
      event_strobe = random ? 1'(rand_bits(1)) : 1'b1;
      sent += int'(event_strobe);
    end
    @(negedge ctrlport_clk);
    event_strobe = 1'b0;
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %s: passed", name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_before);
    end
  endtask

  // ----------------------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------------------

  initial begin
    logic [31:0] word;
    logic [31:0] rdata;
    logic [31:0] lo;
    logic [31:0] hi;
    logic [63:0] preset;
    logic [63:0] stamp;
    int          mark;
    int          start;
    int          elapsed;
    int          events;
    int          dropped;

    repeat (3) @(posedge ctrlport_clk);
    @(negedge ctrlport_clk);
    rst_n = 1'b1;

    // Each write is followed at once by its read, all back to back
    mark = errors;
    for (int i = 0; i < 4; i++) begin
      word = 32'(rand_bits(32));
      issue(1'b1, addr_scratch, word, status_okay, 32'd0, 1'b1);
      issue(1'b0, addr_scratch, 32'd0, status_okay, word, 1'b1);
    end
    end_burst(rdata);
    report_test("scratch read-back", mark);

    // Unmapped reads and writes into read-only space
    mark = errors;
    rd_reg(20'h20, status_addr_err, 32'd0, 1'b1, rdata);
    rd_reg(20'h40, status_addr_err, 32'd0, 1'b1, rdata);
    wr_reg(addr_timestamp, 32'(rand_bits(32)), status_addr_err);
    wr_reg(addr_event_count, 32'(rand_bits(32)), status_addr_err);
    report_test("address errors", mark);

    // Counting is off after reset, so the timestamp mirrors the preset
    mark = errors;
    preset = rand_bits(64);
    wr_reg(addr_ts_preset, preset[31:0], status_okay);
    wr_reg(addr_ts_preset + 20'h4, preset[63:32], status_okay);
    rd_reg(addr_timestamp, status_okay, preset[31:0], 1'b1, rdata);
    rd_reg(addr_timestamp + 20'h4, status_okay, preset[63:32], 1'b1, rdata);
    rd_reg(addr_ts_preset, status_okay, preset[31:0], 1'b1, rdata);
    rd_reg(addr_ts_preset + 20'h4, status_okay, preset[63:32], 1'b1, rdata);
    word = 32'(rand_bits(32));
    wr_reg(addr_control, word, status_okay);
    rd_reg(addr_control, status_okay, {30'd0, word[1:0]}, 1'b1, rdata);
    wr_reg(addr_control, 32'd0, status_okay);
    report_test("preset and hold", mark);

    // The low word sits 16 counts below a carry into the high word
    mark = errors;
    preset = 64'h0000_0001_FFFF_FFF0;
    wr_reg(addr_ts_preset, preset[31:0], status_okay);
    wr_reg(addr_ts_preset + 20'h4, preset[63:32], status_okay);
    start = cycle_cnt;
    wr_reg(addr_control, 32'd1, status_okay);
    for (int pass = 0; pass < 2; pass++) begin
      // The second pass reads well after the low word has wrapped
      repeat (int'(rand_bits(3)) + 20 * pass) @(negedge ctrlport_clk);
      rd_reg(addr_timestamp, status_okay, 32'd0, 1'b0, lo);
      elapsed = cycle_cnt - start;
      repeat (int'(rand_bits(3)) + 1) @(negedge ctrlport_clk);
      rd_reg(addr_timestamp + 20'h4, status_okay, 32'd0, 1'b0, hi);
      stamp = {hi, lo};
      assert (hi == ((lo < 32'hFFFF_FFF0) ? 32'd2 : 32'd1)) else begin
        errors++;
        $display("error at %0t: high word %h does not fit low word %h", $time, hi, lo);
      end
      assert (stamp >= preset && stamp <= preset + 64'(elapsed)) else begin
        errors++;
        $display("error at %0t: timestamp %h outside %h plus %0d", $time,
                 stamp, preset, elapsed);
      end
    end
    wr_reg(addr_control, 32'd0, status_okay);
    report_test("coherent timestamp", mark);

    mark = errors;
    wr_reg(addr_control, 32'd2, status_okay);
    pulse_events(48, 1'b1, events);
    rd_reg(addr_event_count, status_okay, 32'(events), 1'b1, rdata);
    rd_reg(addr_event_count + 20'h4, status_okay, 32'd0, 1'b1, rdata);
    // With counting off these strobes must leave the count alone
    wr_reg(addr_control, 32'd0, status_okay);
    pulse_events(16, 1'b0, dropped);
    rd_reg(addr_event_count, status_okay, 32'(events), 1'b1, rdata);
    report_test("event counter", mark);

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("the watchdog expired before the tests finished");
    $display("Some tests failed");
    $finish;
  end

endmodule

// ==== design/ctrlport_status_block.sv ====
module ctrlport_status_block
  import ctrlport_pkg::*;
(
  input  logic           ctrlport_clk,
  input  logic           rst_n,
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp,
  input  logic           event_strobe
);

  // One reply slot per register block, ORed together by the merger
  ctrlport_resp_t [num_responders-1:0] resp_vec;

  logic [1:0]  ctrl_bits;
  ctrl_word_u  ctrl_word;
  logic [63:0] ts_preset;
  logic [63:0] timestamp;
  logic [39:0] event_count;

  // Only the two low control bits are stored, the rest read as zero
  assign ctrl_word.raw = {30'd0, ctrl_bits};

  // ----------------------------------------------------------------------
  // Read-write registers
  // ----------------------------------------------------------------------

  // General scratch word with no side effects
  ctrlport_reg_rw #(
    .ADDR        (addr_scratch),
    .WIDTH       (32),
    .RESET_VALUE (32'd0)
  ) i_scratch (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (resp_vec[0]),
    .value        ()
  );

  // Reset leaves both counters disabled
  ctrlport_reg_rw #(
    .ADDR        (addr_control),
    .WIDTH       (2),
    .RESET_VALUE (2'd0)
  ) i_control (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (resp_vec[1]),
    .value        (ctrl_bits)
  );

  // Spans 0x10 and 0x14
  ctrlport_reg_rw #(
    .ADDR        (addr_ts_preset),
    .WIDTH       (64),
    .RESET_VALUE (64'd0)
  ) i_ts_preset (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (resp_vec[2]),
    .value        (ts_preset)
  );

  // ----------------------------------------------------------------------
  // Read-only registers
  // ----------------------------------------------------------------------

  // Low word first, the high word then comes from the same snapshot
  ctrlport_reg_ro #(
    .ADDR     (addr_timestamp),
    .WIDTH    (64),
    .COHERENT (1'b1)
  ) i_timestamp (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (resp_vec[3]),
    .value        (timestamp)
  );

  ctrlport_reg_ro #(
    .ADDR     (addr_event_count),
    .WIDTH    (40),
    .COHERENT (1'b0)
  ) i_event_count (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .s_resp       (resp_vec[4]),
    .value        (event_count)
  );

  // ----------------------------------------------------------------------
  // Response merge and counters
  // ----------------------------------------------------------------------

  ctrlport_resp_merge #(
    .NUM_RESP (num_responders)
  ) i_resp_merge (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .s_req        (s_req),
    .resp_vec     (resp_vec),
    .s_resp       (s_resp)
  );

  status_counters i_counters (
    .ctrlport_clk (ctrlport_clk),
    .rst_n        (rst_n),
    .ctrl         (ctrl_word),
    .ts_preset    (ts_preset),
    .event_strobe (event_strobe),
    .timestamp    (timestamp),
    .event_count  (event_count)
  );

endmodule

// ==== design/status_counters.sv ====
module status_counters
  import ctrlport_pkg::*;
(
  input  logic        ctrlport_clk,
  input  logic        rst_n,
  input  ctrl_word_u  ctrl,
  input  logic [63:0] ts_preset,
  input  logic        event_strobe,
  output logic [63:0] timestamp,
  output logic [39:0] event_count
);

  logic ts_enable;
  logic event_enable;

  // Decode the raw control word through its field view
  assign ts_enable    = ctrl.fields.ts_enable;
  assign event_enable = ctrl.fields.event_enable;

  // ----------------------------------------------------------------------
  // Timestamp
  // ----------------------------------------------------------------------

  // While disabled the timestamp tracks the preset every cycle, so the
  // first enabled cycle counts up from whatever preset was last written
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      timestamp <= '0;
    end else if (!ts_enable) begin
      timestamp <= ts_preset;
    end else begin
      // Wraps to zero past full scale
      timestamp <= timestamp + 64'd1;
    end
  end

  // ----------------------------------------------------------------------
  // Event counter
  // ----------------------------------------------------------------------

  // Strobes are dropped, not deferred, while counting is off
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      event_count <= '0;
    end else if (event_enable && event_strobe) begin
      event_count <= event_count + 40'd1;
    end
  end

endmodule

// ==== design/ctrlport_resp_merge.sv ====
module ctrlport_resp_merge
  import ctrlport_pkg::*;
#(
  parameter int NUM_RESP = 2
) (
  input  logic                          ctrlport_clk,
  input  logic                          rst_n,
  input  ctrlport_req_t                 s_req,
  input  ctrlport_resp_t [NUM_RESP-1:0] resp_vec,
  output ctrlport_resp_t                s_resp
);

  logic                pending;
  logic [NUM_RESP-1:0] ack_vec;
  ctrlport_resp_t      merged;

  // Every strobe expects exactly one reply in the next cycle
  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      pending <= 1'b0;
    end else begin
      pending <= s_req.rd || s_req.wr;
    end
  end

  // ----------------------------------------------------------------------
  // Combine the replies
  // ----------------------------------------------------------------------

  // Idle blocks may hold stale data, so only acking replies are ORed in
  always_comb begin
    merged = '0;
    for (int i = 0; i < NUM_RESP; i++) begin
      ack_vec[i] = resp_vec[i].ack;
      if (resp_vec[i].ack) begin
        merged = merged | resp_vec[i];
      end
    end
  end

  // A request that no block claimed is answered here as an address error.
  // With no ack the merged word stays all zero and so carries zero data
  assign s_resp.ack    = pending;
  assign s_resp.status = (|ack_vec) ? merged.status : status_addr_err;
  assign s_resp.data   = merged.data;

  // The address map must not overlap
  a_single_ack : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    $onehot0(ack_vec)
  );

  // No register block may answer a cycle that had no request before it
  a_ack_when_pending : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    (|ack_vec) |-> pending
  );

endmodule

// ==== design/ctrlport_reg_rw.sv ====
module ctrlport_reg_rw
  import ctrlport_pkg::*;
#(
  parameter logic [19:0]      ADDR        = '0,
  parameter int               WIDTH       = 32,
  parameter logic [WIDTH-1:0] RESET_VALUE = '0
) (
  input  logic             ctrlport_clk,
  input  logic             rst_n,
  input  ctrlport_req_t    s_req,
  output ctrlport_resp_t   s_resp,
  output logic [WIDTH-1:0] value
);

  // ----------------------------------------------------------------------
  // Region geometry
  // ----------------------------------------------------------------------

  localparam int NUM_BYTES   = region_bytes(WIDTH);
  localparam int NUM_WORDS   = NUM_BYTES / 4;
  localparam int BYTE_ADDR_W = $clog2(NUM_BYTES);
  localparam int WORD_ADDR_W = BYTE_ADDR_W - 2;
  localparam int IDX_W       = (WORD_ADDR_W > 0) ? WORD_ADDR_W : 1;

  if (WIDTH < 1) begin : gen_width_check
    $error("ctrlport_reg_rw: WIDTH must be at least 1");
  end

  if (ADDR[BYTE_ADDR_W-1:0] != '0) begin : gen_addr_check
    $error("ctrlport_reg_rw: ADDR must be aligned to the register region");
  end

  logic [NUM_WORDS-1:0][31:0] words;
  logic [NUM_WORDS-1:0][31:0] words_next;
  logic [IDX_W-1:0]           word_idx;
  logic                       hit;
  logic                       ack;
  logic [31:0]                data;

  assign words    = (NUM_WORDS * 32)'(value);
  assign word_idx = (WORD_ADDR_W > 0) ? s_req.addr[2 +: IDX_W] : '0;
  assign hit      = s_req.addr[19:BYTE_ADDR_W] == ADDR[19:BYTE_ADDR_W];

  // Replace only the addressed word, the others keep their contents
  always_comb begin
    words_next           = words;
    words_next[word_idx] = s_req.data;
  end

  // ----------------------------------------------------------------------
  // Storage and acknowledge
  // ----------------------------------------------------------------------

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack   <= 1'b0;
      value <= RESET_VALUE;
    end else begin
      ack <= hit && (s_req.rd || s_req.wr);
      // The new value shows in the same cycle as the write ack.
      // Bits above WIDTH are cut off here
      if (hit && s_req.wr) begin
        value <= WIDTH'(words_next);
      end
    end
  end

  // Read data follows the stored value, zero-filled above WIDTH
  always_ff @(posedge ctrlport_clk) begin
    if (hit && s_req.rd) begin
      data <= words[word_idx];
    end else if (hit && s_req.wr) begin
      data <= '0;
    end
  end

  assign s_resp.ack    = ack;
  assign s_resp.status = status_okay;
  assign s_resp.data   = data;

endmodule

// ==== design/ctrlport_reg_ro.sv ====
module ctrlport_reg_ro
  import ctrlport_pkg::*;
#(
  parameter logic [19:0] ADDR     = '0,
  parameter int          WIDTH    = 32,
  parameter bit          COHERENT = 1'b0
) (
  input  logic           ctrlport_clk,
  input  logic           rst_n,
  input  ctrlport_req_t  s_req,
  output ctrlport_resp_t s_resp,
  input  logic [WIDTH-1:0] value
);

  // ----------------------------------------------------------------------
  // Region geometry
  // ----------------------------------------------------------------------

  localparam int NUM_BYTES   = region_bytes(WIDTH);
  localparam int NUM_WORDS   = NUM_BYTES / 4;
  localparam int BYTE_ADDR_W = $clog2(NUM_BYTES);
  localparam int WORD_ADDR_W = BYTE_ADDR_W - 2;
  // Keep the word index at least one bit wide even for single-word registers
  localparam int IDX_W       = (WORD_ADDR_W > 0) ? WORD_ADDR_W : 1;

  if (WIDTH < 1) begin : gen_width_check
    $error("ctrlport_reg_ro: WIDTH must be at least 1");
  end

  if (ADDR[BYTE_ADDR_W-1:0] != '0) begin : gen_addr_check
    $error("ctrlport_reg_ro: ADDR must be aligned to the register region");
  end

  logic [NUM_WORDS-1:0][31:0] words;
  logic [IDX_W-1:0]           word_idx;
  logic                       rd_hit;
  logic                       ack;
  logic [31:0]                data;

  // Zero-fill the value up to a whole number of words
  assign words    = (NUM_WORDS * 32)'(value);
  assign word_idx = (WORD_ADDR_W > 0) ? s_req.addr[2 +: IDX_W] : '0;
  // Only the bits above the region size take part in the decode
  assign rd_hit   = s_req.rd && (s_req.addr[19:BYTE_ADDR_W] == ADDR[19:BYTE_ADDR_W]);

  always_ff @(posedge ctrlport_clk or negedge rst_n) begin
    if (!rst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= rd_hit;
    end
  end

  // ----------------------------------------------------------------------
  // Read data
  // ----------------------------------------------------------------------

  if (COHERENT && (WIDTH > 32)) begin : gen_coherent
    // Snapshot of the whole value, taken when the lowest word is read
    logic [NUM_WORDS-1:0][31:0] cache;

    always_ff @(posedge ctrlport_clk) begin
      if (rd_hit) begin
        if (word_idx == '0) begin
          data  <= words[0];
          cache <= words;
        end else begin
          // Upper words come from the snapshot so a carry between reads is not seen
          data <= cache[word_idx];
        end
      end
    end
  end else begin : gen_direct
    // Every word is read live and on its own
    always_ff @(posedge ctrlport_clk) begin
      if (rd_hit) begin
        data <= words[word_idx];
      end
    end
  end

  // Read-only registers never fail a read they claim
  assign s_resp.ack    = ack;
  assign s_resp.status = status_okay;
  assign s_resp.data   = data;

  // An ack here must always trace back to a read strobe one cycle earlier
  a_ack_needs_read : assert property (
    @(posedge ctrlport_clk) disable iff (!rst_n)
    ack |-> $past(s_req.rd)
  );

endmodule

// ==== design/ctrlport_pkg.sv ====
package ctrlport_pkg;

  // ----------------------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------------------

  // One request beat, valid only in the cycle that rd or wr is high
  typedef struct packed {
    logic        wr;
    logic        rd;
    logic [19:0] addr;
    logic [31:0] data;
  } ctrlport_req_t;

  // One response beat, data is zero for writes and for errors
  typedef struct packed {
    logic        ack;
    logic [1:0]  status;
    logic [31:0] data;
  } ctrlport_resp_t;

  typedef enum logic [1:0] {
    status_okay     = 2'd0,
    status_addr_err = 2'd3
  } ctrlport_status_e;

  // ----------------------------------------------------------------------
  // Control word
  // ----------------------------------------------------------------------

  typedef struct packed {
    logic [29:0] reserved;
    logic        event_enable;
    logic        ts_enable;
  } ctrl_fields_t;

  // The control register keeps raw bus data, the counters decode it as fields
  typedef union packed {
    logic [31:0]  raw;
    ctrl_fields_t fields;
  } ctrl_word_u;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------

  localparam logic [19:0] addr_scratch     = 20'h00;
  localparam logic [19:0] addr_control     = 20'h04;
  localparam logic [19:0] addr_timestamp   = 20'h08;
  localparam logic [19:0] addr_ts_preset   = 20'h10;
  localparam logic [19:0] addr_event_count = 20'h18;

  // Register blocks that feed the response merger
  localparam int num_responders = 5;

  // Bytes of address space that a register of the given width occupies.
  // Always a power of two and never below one 32-bit word
  function automatic int region_bytes(input int width);
    return (width <= 32) ? 4 : (2 ** $clog2(width)) / 8;
  endfunction

endpackage
